/* logic/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// reset vector after power-up
`define FETCH_RST_PC 32'h0000_0000

// address and data width
`define FETCH_XLEN 32

// pc step for sequential fetch
`define FETCH_INC_16 2 // compressed word
`define FETCH_INC_32 4 // full word

`endif

/* logic/fetch_pkg.sv */
`default_nettype none
`include "fetch_consts.svh"

package fetch_pkg;

	// B-format layout, imm bit 0 implied zero
	typedef struct packed {
		logic imm_12; // sign bit
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} rv_b_t;

	// J-format layout for jal
	typedef struct packed {
		logic imm_20; // sign bit
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_t;

	// I-format layout for jalr
	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_i_t;

	// one fetched word, three immediate layouts
	typedef union packed {
		rv_b_t b;
		rv_j_t j;
		rv_i_t i;
	} rv_inst_u;

	typedef struct packed {
		logic len_type; // 1 -> 32-bit word
		logic is_b;
		logic is_jal;
		logic is_jalr;
		logic signed [20:0] jump_ofs; // sign-extended offset
	} predec_t;

	typedef struct packed {
		logic out_vld;
		logic [`FETCH_XLEN-1:0] pc;
		logic [`FETCH_XLEN-1:0] inst;
		logic pred_jump;
		logic [`FETCH_XLEN-1:0] pred_pc; // address after this instruction
	} fetch_out_t;

	typedef struct packed {
		logic wr_en; // write strobe
		logic [1:0] sel; // 0 rst vector, 1 ctrl
		logic [`FETCH_XLEN-1:0] data;
	} cfg_wr_t;

endpackage

`default_nettype wire

/* logic/fetch_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_cfg_regs
	import fetch_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input cfg_wr_t cfg_wr,
	output logic [`FETCH_XLEN-1:0] rst_vec,
	output logic bpred_en
);

	localparam logic [1:0] SEL_RST_VEC = 2'd0;
	localparam logic [1:0] SEL_CTRL = 2'd1; // sel 2 and 3 unmapped

	// survives arst_n so a rewritten vector applies on the next reset
	logic [`FETCH_XLEN-1:0] rst_vec_q = `FETCH_RST_PC;
	logic bpred_en_q;
	logic wr_vec;
	logic wr_ctrl;

	assign wr_vec = cfg_wr.wr_en && (cfg_wr.sel == SEL_RST_VEC);
	assign wr_ctrl = cfg_wr.wr_en && (cfg_wr.sel == SEL_CTRL);

	always_ff @(posedge clk) begin
		if (wr_vec) begin
			rst_vec_q <= cfg_wr.data;
		end
	end

	// ctrl bit 0, backward-branch prediction on after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bpred_en_q <= 1'b1;
		end else if (wr_ctrl) begin
			bpred_en_q <= cfg_wr.data[0];
		end
	end

	assign rst_vec = rst_vec_q;
	assign bpred_en = bpred_en_q;

	// vector stays a legal halfword fetch address
	a_vec_align: assert property (@(posedge clk) disable iff (!arst_n)
		wr_vec |=> (rst_vec[0] == 1'b0));

	a_sel_known: assert property (@(posedge clk) disable iff (!arst_n)
		cfg_wr.wr_en |-> !$isunknown(cfg_wr.sel));

endmodule

`default_nettype wire

/* logic/inst_predecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module inst_predecode
	import fetch_pkg::*;
(
	input logic [`FETCH_XLEN-1:0] inst,
	output predec_t pd
);

	// major opcodes, full-width words only
	localparam logic [6:0] OPC_B = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;

	rv_inst_u iw; // same word, three views
	logic is_32;
	logic is_b;
	logic is_jal;
	logic is_jalr;
	logic [20:0] imm_b;
	logic [20:0] imm_j;
	logic [20:0] imm_i;

	assign iw = inst;

	// low bits 2'b11 mark a 32-bit word
	assign is_32 = &iw.i.opcode[1:0];

	// compressed words never decode as control flow here
	assign is_b = is_32 && (iw.b.opcode == OPC_B);
	assign is_jal = is_32 && (iw.j.opcode == OPC_JAL);
	assign is_jalr = is_32 && (iw.i.opcode == OPC_JALR);

	// B immediate 13 bits, lsb always 0
	assign imm_b = {
		{8{iw.b.imm_12}}, // sign ext
		iw.b.imm_12,
		iw.b.imm_11,
		iw.b.imm_10_5,
		iw.b.imm_4_1,
		1'b0
	};

	// J immediate already 21 bits wide
	assign imm_j = {
		iw.j.imm_20,
		iw.j.imm_19_12,
		iw.j.imm_11,
		iw.j.imm_10_1,
		1'b0
	};

	// I immediate 12 bits, widened to 21
	assign imm_i = {{9{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};

	always_comb begin
		pd.len_type = is_32;
		pd.is_b = is_b;
		pd.is_jal = is_jal;
		pd.is_jalr = is_jalr;

		// pick offset by class
		if (is_b) begin
			pd.jump_ofs = imm_b;
		end else if (is_jal) begin
			pd.jump_ofs = imm_j;
		end else if (is_jalr) begin
			pd.jump_ofs = imm_i;
		end else begin
			pd.jump_ofs = '0; // not a jump
		end
	end

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module pc_gen
	import fetch_pkg::*;
(
	input logic [`FETCH_XLEN-1:0] now_pc,
	input logic [`FETCH_XLEN-1:0] rs1_v,
	input logic to_rst,
	input logic to_flush,
	input logic [`FETCH_XLEN-1:0] flush_addr_hold,
	input logic [`FETCH_XLEN-1:0] rst_vec,
	input logic bpred_en,
	input predec_t pd,
	output logic to_jump,
	output logic [`FETCH_XLEN-1:0] new_pc
);

	logic [`FETCH_XLEN-1:0] ofs_ext; // offset at full width
	logic [`FETCH_XLEN-1:0] seq_inc;
	logic [`FETCH_XLEN-1:0] add_a;
	logic [`FETCH_XLEN-1:0] add_b;
	logic [`FETCH_XLEN-1:0] pc_sum;
	logic [`FETCH_XLEN-1:0] pc_nxt;

	// backward branch taken, forward not taken
	// jal and jalr always taken
	assign to_jump = (pd.is_b & pd.jump_ofs[20] & bpred_en) | pd.is_jal | pd.is_jalr;

	assign ofs_ext = {{(`FETCH_XLEN-21){pd.jump_ofs[20]}}, pd.jump_ofs};
	assign seq_inc = pd.len_type ? `FETCH_INC_32 : `FETCH_INC_16;

	// one adder shared by target and sequential paths
	// jalr bases on rs1, everything else on pc
	assign add_a = (to_jump && pd.is_jalr) ? rs1_v : now_pc;
	assign add_b = to_jump ? ofs_ext : seq_inc;
	assign pc_sum = add_a + add_b;

	// jalr target has bit 0 cleared
	assign pc_nxt = (to_jump && pd.is_jalr) ? {pc_sum[`FETCH_XLEN-1:1], 1'b0} : pc_sum;

	// reset wins, then pending flush
	always_comb begin
		if (to_rst) begin
			new_pc = rst_vec;
		end else if (to_flush) begin
			new_pc = flush_addr_hold;
		end else begin
			new_pc = pc_nxt;
		end
	end

endmodule

`default_nettype wire

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_ctrl
	import fetch_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic flush, // single-cycle pulse
	input logic [`FETCH_XLEN-1:0] flush_addr,
	input logic [`FETCH_XLEN-1:0] inst,
	input logic [`FETCH_XLEN-1:0] rst_vec,
	input logic to_jump,
	input logic [`FETCH_XLEN-1:0] new_pc,
	output logic [`FETCH_XLEN-1:0] now_pc,
	output logic to_rst,
	output logic to_flush,
	output logic [`FETCH_XLEN-1:0] flush_addr_hold,
	output fetch_out_t fout
);

	logic [`FETCH_XLEN-1:0] pc_q;
	logic rst_req; // one cycle after release
	logic flush_pend;
	logic [`FETCH_XLEN-1:0] flush_addr_q;
	logic out_vld;
	logic pc_ld;

	// high through reset and the first cycle after it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rst_req <= 1'b1;
		end else begin
			rst_req <= 1'b0;
		end
	end

	// set for the cycle after each flush pulse, reset request included
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flush_pend <= 1'b0;
		end else begin
			flush_pend <= flush;
		end
	end

	always_ff @(posedge clk) begin
		if (flush) begin
			flush_addr_q <= flush_addr; // latest pulse wins
		end
	end

	assign to_rst = rst_req;
	assign to_flush = flush_pend;
	assign flush_addr_hold = flush_addr_q;

	assign out_vld = ~rst_req & ~flush_pend;

	// reset and flush loads ignore stall
	assign pc_ld = rst_req | flush_pend | (out_vld & ~stall);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= `FETCH_RST_PC;
		end else if (pc_ld) begin
			pc_q <= new_pc;
		end
	end

	// vector shows on the bus while reset is requested
	assign now_pc = rst_req ? rst_vec : pc_q;

	always_comb begin
		fout.out_vld = out_vld;
		fout.pc = now_pc;
		fout.inst = inst; // comb read at now_pc
		fout.pred_jump = to_jump;
		fout.pred_pc = new_pc;
	end

	// every source of the pc keeps halfword alignment
	a_pc_align: assert property (@(posedge clk) disable iff (!arst_n)
		now_pc[0] == 1'b0);

	// back-pressure holds the fetch address even as the reset request ends
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(stall && !to_flush) |=> $stable(now_pc));

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_top
	import fetch_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [`FETCH_XLEN-1:0] inst, // imem read at fetch_pc
	input logic [`FETCH_XLEN-1:0] rs1_v,
	input logic stall,
	input logic flush,
	input logic [`FETCH_XLEN-1:0] flush_addr,
	input cfg_wr_t cfg_wr,
	output logic [`FETCH_XLEN-1:0] fetch_pc,
	output fetch_out_t fout
);

	logic [`FETCH_XLEN-1:0] rst_vec;
	logic bpred_en;
	logic to_rst;
	logic to_flush;
	logic [`FETCH_XLEN-1:0] flush_addr_hold;
	logic to_jump;
	logic [`FETCH_XLEN-1:0] new_pc;
	predec_t pd;

	fetch_cfg_regs cfg_regs_i (
		.clk(clk),
		.arst_n(arst_n),
		.cfg_wr(cfg_wr),
		.rst_vec(rst_vec),
		.bpred_en(bpred_en)
	);

	// pc register drives the memory address directly
	fetch_ctrl ctrl_i (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.flush(flush),
		.flush_addr(flush_addr),
		.inst(inst),
		.rst_vec(rst_vec),
		.to_jump(to_jump),
		.new_pc(new_pc),
		.now_pc(fetch_pc),
		.to_rst(to_rst),
		.to_flush(to_flush),
		.flush_addr_hold(flush_addr_hold),
		.fout(fout)
	);

	inst_predecode predecode_i (
		.inst(inst),
		.pd(pd)
	);

	pc_gen pc_gen_i (
		.now_pc(fetch_pc),
		.rs1_v(rs1_v),
		.to_rst(to_rst),
		.to_flush(to_flush),
		.flush_addr_hold(flush_addr_hold),
		.rst_vec(rst_vec),
		.bpred_en(bpred_en),
		.pd(pd),
		.to_jump(to_jump),
		.new_pc(new_pc)
	);

endmodule

`default_nettype wire

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module tb_fetch_top
	import fetch_pkg::*;
;

	logic clk;
	logic arst_n;
	logic [`FETCH_XLEN-1:0] inst;
	logic [`FETCH_XLEN-1:0] rs1_v;
	logic stall;
	logic flush;
	logic [`FETCH_XLEN-1:0] flush_addr;
	cfg_wr_t cfg_wr;
	logic [`FETCH_XLEN-1:0] fetch_pc;
	fetch_out_t fout;

	logic [31:0] prog [0:1023]; // program memory indexed by folded address

	// reference model state
	logic [31:0] m_pc;
	logic m_rst_req;
	logic m_flush_pend;
	logic [31:0] m_flush_addr;
	logic [31:0] m_rst_vec;
	logic m_bpred_en;
	int err_cnt;

	fetch_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.inst(inst),
		.rs1_v(rs1_v),
		.stall(stall),
		.flush(flush),
		.flush_addr(flush_addr),
		.cfg_wr(cfg_wr),
		.fetch_pc(fetch_pc),
		.fout(fout)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// every address bit above bit 0 lands in the index
	function automatic logic [9:0] fold_addr(input logic [31:0] a);
		return a[10:1] ^ a[20:11] ^ a[30:21] ^ {9'b0, a[31]};
	endfunction

	assign inst = prog[fold_addr(fetch_pc)]; // comb imem read

	function automatic logic [31:0] make_word();
		logic [31:0] w;
		w = $urandom;
		case ($urandom_range(0, 6))
			0, 1: w[1:0] = 2'($urandom_range(0, 2)); // compressed
			2: w[6:0] = 7'b0110011; // alu reg-reg
			3: w[6:0] = 7'b0010011; // alu imm
			4: w[6:0] = 7'b1100011; // branch with bit 31 picking direction
			5: w[6:0] = 7'b1101111; // jal
			default: w[6:0] = 7'b1100111; // jalr
		endcase
		return w;
	endfunction

	// static prediction rules with immediates sliced straight from the word
	function automatic void predict(input logic [31:0] w, input logic [31:0] pc,
		input logic [31:0] rs1, input logic bp_en,
		output logic jump, output logic [31:0] tgt);
		rv_inst_u iw;
		logic full;
		logic [31:0] ofs;
		iw = w;
		full = (w[1:0] == 2'b11);
		jump = 1'b0;
		tgt = pc + (full ? `FETCH_INC_32 : `FETCH_INC_16);
		if (full && iw.b.opcode == 7'b1100011) begin
			ofs = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			if (bp_en && w[31]) begin
				jump = 1'b1; // backward only
				tgt = pc + ofs;
			end
		end else if (full && iw.j.opcode == 7'b1101111) begin
			ofs = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			jump = 1'b1;
			tgt = pc + ofs;
		end else if (full && iw.i.opcode == 7'b1100111) begin
			ofs = {{20{w[31]}}, w[31:20]};
			jump = 1'b1;
			tgt = (rs1 + ofs) & ~32'h1; // lsb dropped
		end
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			err_cnt++;
			abort_run($sformatf("ERROR %0t: %s got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_fout(input fetch_out_t got, input fetch_out_t exp);
		if (got !== exp) begin
			err_cnt++;
			abort_run({$sformatf("ERROR %0t: fout got vld=%b pc=%h inst=%h jmp=%b nxt=%h",
				$time, got.out_vld, got.pc, got.inst, got.pred_jump, got.pred_pc),
				$sformatf(" expected vld=%b pc=%h inst=%h jmp=%b nxt=%h",
				exp.out_vld, exp.pc, exp.inst, exp.pred_jump, exp.pred_pc)});
		end
	endtask

	task automatic drive_idle();
		stall = 1'b0;
		flush = 1'b0;
		flush_addr = '0;
		rs1_v = '0;
		cfg_wr = '0;
	endtask

	task automatic drive_random(input logic cfg_ok);
		stall = ($urandom_range(0, 3) == 0);
		flush = ($urandom_range(0, 19) == 0);
		flush_addr = $urandom & 32'hFFFF_FFFE; // halfword aligned
		rs1_v = $urandom;
		cfg_wr.wr_en = cfg_ok && ($urandom_range(0, 49) == 0);
		cfg_wr.sel = 2'($urandom_range(0, 3)); // 2 and 3 unmapped
		cfg_wr.data = $urandom;
		if (cfg_wr.sel == 2'd0) begin
			cfg_wr.data[0] = 1'b0; // legal vector only
		end
	endtask

	// runs from one falling edge with inputs set to the next one
	task automatic step();
		fetch_out_t exp;
		logic [31:0] cur_pc;
		logic jmp;
		logic [31:0] tgt;
		#2;
		cur_pc = m_rst_req ? m_rst_vec : m_pc;
		predict(prog[fold_addr(cur_pc)], cur_pc, rs1_v, m_bpred_en, jmp, tgt);
		exp.out_vld = !m_rst_req && !m_flush_pend;
		exp.pc = cur_pc;
		exp.inst = prog[fold_addr(cur_pc)];
		exp.pred_jump = jmp;
		exp.pred_pc = m_rst_req ? m_rst_vec : (m_flush_pend ? m_flush_addr : tgt);
		check_pc(fetch_pc, cur_pc, "fetch_pc");
		check_fout(fout, exp);
		// next state where reset and flush ignore stall
		if (m_rst_req || m_flush_pend || (exp.out_vld && !stall)) begin
			m_pc = exp.pred_pc;
		end
		if (flush) begin
			m_flush_addr = flush_addr;
		end
		m_flush_pend = flush; // taken the next cycle
		m_rst_req = 1'b0;
		if (cfg_wr.wr_en && cfg_wr.sel == 2'd0) begin
			m_rst_vec = cfg_wr.data;
		end else if (cfg_wr.wr_en && cfg_wr.sel == 2'd1) begin
			m_bpred_en = cfg_wr.data[0];
		end
		@(negedge clk);
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		drive_idle();
		repeat (16) @(negedge clk);
		arst_n = 1'b1; // released on a falling edge
		m_rst_req = 1'b1;
		m_flush_pend = 1'b0;
		m_bpred_en = 1'b1;
	endtask

	task automatic wait_fetch_valid(input int limit);
		int n;
		n = 0;
		while (fout.out_vld !== 1'b1) begin
			if (n == limit) begin
				abort_run("timeout: fetch output never became valid after reset");
			end
			drive_idle();
			stall = ($urandom_range(0, 1) == 1); // the reset load ignores stall
			step();
			n++;
		end
	endtask

	task automatic write_cfg(input logic [1:0] sel, input logic [31:0] data);
		drive_idle();
		cfg_wr.wr_en = 1'b1;
		cfg_wr.sel = sel;
		cfg_wr.data = data;
		step();
	endtask

	initial begin
		logic [31:0] new_vec;
		void'($urandom(12396));
		err_cnt = 0;
		arst_n = 1'b0;
		drive_idle();
		m_pc = `FETCH_RST_PC;
		m_rst_vec = `FETCH_RST_PC;
		m_flush_addr = '0;
		for (int i = 0; i < 1024; i++) begin
			prog[i] = make_word();
		end

		apply_reset();
		check_pc(fetch_pc, `FETCH_RST_PC, "pc in reset request cycle");
		wait_fetch_valid(4);
		check_pc(fetch_pc, `FETCH_RST_PC, "first fetch pc");

		// mixed traffic incl. random config writes
		repeat (2000) begin
			drive_random(1'b1);
			step();
		end

		// backward branches must not predict now
		write_cfg(2'd1, 32'h0);
		repeat (500) begin
			drive_random(1'b0);
			step();
		end
		write_cfg(2'd1, 32'h1);

		// new vector only used by the next reset
		new_vec = ($urandom & 32'h000F_FFF0) | 32'h0000_1000;
		write_cfg(2'd0, new_vec);
		repeat (20) begin
			drive_random(1'b0);
			step();
		end
		apply_reset();
		check_pc(fetch_pc, new_vec, "pc in second reset request");
		wait_fetch_valid(4);
		check_pc(fetch_pc, new_vec, "first fetch after second reset");

		repeat (1000) begin
			drive_random(1'b1);
			step();
		end

		if (err_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* panda_fetch.f */
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_cfg_regs.sv
logic/inst_predecode.sv
logic/pc_gen.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
testbench/tb_fetch_top.sv
